//--- scroll_pkg.sv
/*
 * Shared definitions for the tile-map scroll layer.
 * Holds the screen and map geometry, the APB register offsets,
 * the packed structs passed between blocks and the FSM state types.
 */
package scroll_pkg;

    localparam int SCREEN_W     = 320;
    localparam int TILES_ACROSS = 21;   // 20 full tiles plus one for the fine scroll
    localparam int TILE_SIZE    = 16;
    localparam int MAP_TILES    = 32;
    localparam int NUM_PRIO     = 16;
    localparam int PIXEL_W      = 15;
    localparam int MAP_AW       = 13;
    localparam int MAP_DW       = 16;
    localparam int SCROLL_W     = 10;

    localparam logic [3:0] REG_SCROLL_X = 4'h0;
    localparam logic [3:0] REG_SCROLL_Y = 4'h4;
    localparam logic [3:0] REG_CTRL     = 4'h8;   // bit 0 enable, bit 1 flip

    typedef struct packed {
        logic [2:0]  bank;
        logic [12:0] code;
    } tile_num_t;

    typedef struct packed {
        logic [3:0] rsvd_hi;
        logic [3:0] prio;
        logic       rsvd;
        logic [6:0] palette;
    } tile_attr_t;

    // the same map word seen as a tile number or as an attribute
    typedef union packed {
        tile_num_t  num;
        tile_attr_t attr;
    } map_word_t;

    typedef struct packed {
        logic [12:0]        code;
        logic [2:0]         bank;
        logic [6:0]         palette;
        logic signed [10:0] x;      // screen column of the tile's left edge
    } queue_entry_t;

    typedef struct packed {
        logic        cs;
        logic [12:0] code;
        logic [2:0]  bank;
        logic        half;
        logic [3:0]  row;
    } gfx_req_t;

    typedef struct packed {
        logic        ok;
        logic [31:0] data;
    } gfx_rsp_t;

    typedef struct packed {
        logic [SCROLL_W-1:0] scroll_x;
        logic [SCROLL_W-1:0] scroll_y;
        logic                flip;
        logic                enable;
    } scroll_cfg_t;

    typedef struct packed {
        logic               we;
        logic [8:0]         addr;
        logic [PIXEL_W-1:0] data;
    } buf_wr_t;

    typedef enum logic [1:0] {F_IDLE, F_ISSUE, F_DRAIN} fetch_state_e;
    typedef enum logic [1:0] {R_IDLE, R_WAIT, R_REQ, R_DRAW} render_state_e;

endpackage

//--- scroll_regs.sv
/*
 * APB register block of the scroll layer.
 * Zero wait states. Scroll X at 0x0, scroll Y at 0x4, control at 0x8.
 * Any other offset answers with pslverr, ignores writes and reads 0.
 */
module scroll_regs (
    input  logic                      clk96,
    input  logic                      reset96,
    input  logic [3:0]                paddr_i,
    input  logic                      psel_i,
    input  logic                      penable_i,
    input  logic                      pwrite_i,
    input  logic [31:0]               pwdata_i,
    output logic [31:0]               prdata_o,
    output logic                      pready_o,
    output logic                      pslverr_o,
    output scroll_pkg::scroll_cfg_t   cfg_o
);
    import scroll_pkg::*;

    logic access;
    logic mapped;

    assign access    = psel_i && penable_i;
    assign pready_o  = 1'b1;
    assign pslverr_o = access && !mapped;

    always_comb begin
        mapped   = 1'b1;
        prdata_o = '0;
        case (paddr_i)
            REG_SCROLL_X: prdata_o = 32'(cfg_o.scroll_x);
            REG_SCROLL_Y: prdata_o = 32'(cfg_o.scroll_y);
            REG_CTRL:     prdata_o = {30'd0, cfg_o.flip, cfg_o.enable};
            default:      mapped   = 1'b0;
        endcase
    end

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            cfg_o <= '0;   // layer disabled
        end else if (access && pwrite_i) begin
            case (paddr_i)
                REG_SCROLL_X: cfg_o.scroll_x <= pwdata_i[SCROLL_W-1:0];
                REG_SCROLL_Y: cfg_o.scroll_y <= pwdata_i[SCROLL_W-1:0];
                REG_CTRL: begin
                    cfg_o.enable <= pwdata_i[0];
                    cfg_o.flip   <= pwdata_i[1];
                end
                default: ;
            endcase
        end
    end

endmodule

//--- tile_fetch.sv
/*
 * Walks the 21 tile columns of one line through the tile-map RAM.
 * Reads are issued back to back, attribute then tile number per column,
 * and the data comes back two cycles later. Non-blank tiles are pushed
 * to the priority queue; done_o stays high once the line is scanned.
 */
module tile_fetch (
    input  logic                        clk96,
    input  logic                        reset96,
    input  logic                        start_i,
    input  logic [8:0]                  vrender_i,
    input  scroll_pkg::scroll_cfg_t     cfg_i,
    input  scroll_pkg::map_word_t       map_data_i,
    output logic [scroll_pkg::MAP_AW-1:0] map_addr_o,
    output logic                        push_o,
    output logic [3:0]                  push_prio_o,
    output scroll_pkg::queue_entry_t    entry_o,
    output logic [3:0]                  tile_row_o,
    output logic                        done_o
);
    import scroll_pkg::*;

    localparam logic [5:0] LAST_RD  = 6'(2 * TILES_ACROSS - 1);
    localparam logic [4:0] LAST_COL = 5'(TILES_ACROSS - 1);

    fetch_state_e        state;
    logic [5:0]          idx;        // two read slots per column
    logic [4:0]          row_q;
    logic [SCROLL_W-1:0] sx_q;
    logic [9:0]          vpos;
    logic [6:0]          tag0, tag1, tag2;   // {valid, odd, column} follows the RAM latency
    logic                last_q;
    map_word_t           attr_q;

    assign vpos = 10'(vrender_i) + cfg_i.scroll_y;

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            state      <= F_IDLE;
            idx        <= '0;
            row_q      <= '0;
            sx_q       <= '0;
            tile_row_o <= '0;
            map_addr_o <= '0;
            tag0       <= '0;
            tag1       <= '0;
            tag2       <= '0;
            push_o     <= 1'b0;
            last_q     <= 1'b0;
            done_o     <= 1'b0;
        end else begin
            tag0   <= '0;
            tag1   <= tag0;
            tag2   <= tag1;
            push_o <= tag2[6] && tag2[5] && (map_data_i != '0);   // tile 0 is blank
            last_q <= tag2[6] && tag2[5] && (tag2[4:0] == LAST_COL);
            if (start_i) begin
                state      <= F_ISSUE;
                idx        <= '0;
                row_q      <= vpos[8:4];   // map row wrapping at 32
                tile_row_o <= vpos[3:0];
                sx_q       <= cfg_i.scroll_x;
                done_o     <= 1'b0;
            end else begin
                case (state)
                    F_ISSUE: begin
                        map_addr_o <= {2'b00, row_q, 5'(sx_q[8:4] + idx[5:1]), idx[0]};
                        tag0       <= {1'b1, idx[0], idx[5:1]};
                        idx        <= idx + 6'd1;
                        if (idx == LAST_RD)
                            state <= F_DRAIN;
                    end
                    F_DRAIN: begin
                        if (last_q) begin   // last push reaches the queue this cycle
                            done_o <= 1'b1;
                            state  <= F_IDLE;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk96) begin
        if (tag2[6] && !tag2[5])
            attr_q <= map_data_i;
        if (tag2[6] && tag2[5]) begin
            entry_o.code    <= map_data_i.num.code;
            entry_o.bank    <= map_data_i.num.bank;
            entry_o.palette <= attr_q.attr.palette;
            entry_o.x       <= signed'({2'b00, tag2[4:0], 4'b0000}) - signed'({7'd0, sx_q[3:0]});
            push_prio_o     <= attr_q.attr.prio;
        end
    end

endmodule

//--- prio_queue.sv
/*
 * Sixteen tile queues, one per priority level, 21 slots each.
 * Entries are handed out only after the fetch is done, lowest level
 * first and in push order within a level. pop is answered by valid
 * one cycle later, with the entry and its level.
 */
module prio_queue (
    input  logic                     clk96,
    input  logic                     reset96,
    input  logic                     clear_i,
    input  logic                     push_i,
    input  logic [3:0]               push_prio_i,
    input  scroll_pkg::queue_entry_t entry_i,
    input  logic                     pop_i,
    input  logic                     fetch_done_i,
    output scroll_pkg::queue_entry_t entry_o,
    output logic [3:0]               prio_o,
    output logic                     valid_o,
    output logic                     empty_o
);
    import scroll_pkg::*;

    queue_entry_t        slots [NUM_PRIO][TILES_ACROSS];
    logic [4:0]          cnt [NUM_PRIO];
    logic [4:0]          rd_ptr;     // read slot within the current level
    logic [NUM_PRIO-1:0] occ;
    logic [3:0]          lvl;
    logic                take;

    always_comb begin
        lvl = '0;
        for (int l = NUM_PRIO - 1; l >= 0; l--) begin
            occ[l] = cnt[l] != '0;
            if (occ[l])
                lvl = 4'(l);   // lowest occupied level wins
        end
    end

    // nothing to hand out while fetching or once drained
    assign empty_o = !(fetch_done_i && |occ);
    assign take    = pop_i && !empty_o;

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            for (int l = 0; l < NUM_PRIO; l++)
                cnt[l] <= '0;
            rd_ptr  <= '0;
            valid_o <= 1'b0;
        end else begin
            valid_o <= take;
            if (clear_i) begin
                for (int l = 0; l < NUM_PRIO; l++)
                    cnt[l] <= '0;
                rd_ptr <= '0;
            end else begin
                if (push_i)
                    cnt[push_prio_i] <= cnt[push_prio_i] + 5'd1;
                if (take) begin
                    if (rd_ptr + 5'd1 == cnt[lvl]) begin   // level drained
                        cnt[lvl] <= '0;
                        rd_ptr   <= '0;
                    end else begin
                        rd_ptr <= rd_ptr + 5'd1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk96) begin
        if (push_i)
            slots[push_prio_i][cnt[push_prio_i]] <= entry_i;
        if (take) begin
            entry_o <= slots[lvl][rd_ptr];
            prio_o  <= lvl;
        end
    end

    // one line holds at most 21 tiles so a level never overflows
    a_no_overflow: assert property (@(posedge clk96) disable iff (reset96)
        push_i && !clear_i |-> cnt[push_prio_i] < 5'(TILES_ACROSS));

endmodule

//--- tile_render.sv
/*
 * Pulls queued tiles, fetches both 8-pixel halves of the tile row over
 * the graphics port and writes the opaque pixels into the line buffer,
 * one pixel per cycle. Only screen columns 0 to 319 are written, and
 * flip mirrors the column.
 */
module tile_render (
    input  logic                     clk96,
    input  logic                     reset96,
    input  logic [3:0]               tile_row_i,
    input  scroll_pkg::queue_entry_t entry_i,
    input  logic [3:0]               prio_i,
    input  logic                     valid_i,
    input  logic                     empty_i,
    input  scroll_pkg::scroll_cfg_t  cfg_i,
    input  scroll_pkg::gfx_rsp_t     gfx_rsp_i,
    output logic                     pop_o,
    output scroll_pkg::gfx_req_t     gfx_req_o,
    output scroll_pkg::buf_wr_t      buf_wr_o,
    output logic                     busy_o
);
    import scroll_pkg::*;

    render_state_e      state;
    queue_entry_t       ent_q;
    logic [3:0]         prio_q;
    logic [31:0]        data_q;
    logic [2:0]         nib;       // pixel within the half
    logic [3:0]         pix;
    logic signed [10:0] pos;
    logic               on_screen;

    assign pop_o  = (state == R_IDLE) && !empty_i;
    assign busy_o = state != R_IDLE;

    always_comb begin
        pix       = data_q[4*nib +: 4];
        pos       = ent_q.x + signed'({7'd0, gfx_req_o.half, nib});
        on_screen = !pos[10] && (pos < 11'sd320);
    end

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            state     <= R_IDLE;
            gfx_req_o <= '0;
            buf_wr_o  <= '0;
            nib       <= '0;
        end else begin
            buf_wr_o.we <= 1'b0;
            case (state)
                R_IDLE: if (pop_o) state <= R_WAIT;
                R_WAIT: begin
                    if (valid_i) begin
                        gfx_req_o <= '{cs: 1'b1, code: entry_i.code, bank: entry_i.bank,
                                       half: 1'b0, row: tile_row_i};
                        state     <= R_REQ;
                    end else begin
                        state <= R_IDLE;
                    end
                end
                R_REQ: begin
                    if (gfx_rsp_i.ok) begin   // data is latched in this cycle
                        gfx_req_o.cs <= 1'b0;
                        nib          <= '0;
                        state        <= R_DRAW;
                    end
                end
                R_DRAW: begin
                    buf_wr_o.we   <= (pix != 4'd0) && on_screen;   // 0 is transparent
                    buf_wr_o.addr <= cfg_i.flip ? 9'(11'sd319 - pos) : pos[8:0];
                    buf_wr_o.data <= {prio_q, ent_q.palette, pix};
                    nib           <= nib + 3'd1;
                    if (nib == 3'd7) begin
                        if (gfx_req_o.half) begin
                            state <= R_IDLE;
                        end else begin
                            gfx_req_o.half <= 1'b1;
                            gfx_req_o.cs   <= 1'b1;
                            state          <= R_REQ;
                        end
                    end
                end
                default: state <= R_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk96) begin
        if (state == R_WAIT && valid_i) begin
            ent_q  <= entry_i;
            prio_q <= prio_i;
        end
        if (state == R_REQ && gfx_rsp_i.ok)
            data_q <= gfx_rsp_i.data;
    end

    // request must sit still until the graphics side answers
    a_req_stable: assert property (@(posedge clk96) disable iff (reset96)
        gfx_req_o.cs && !gfx_rsp_i.ok |=> gfx_req_o.cs && $stable(gfx_req_o));

endmodule

//--- line_buffer.sv
/*
 * Double-buffered line memory. The render writes one bank while the
 * other is shown; the banks swap at the end of hblank. Display reads
 * clear the entry so the bank comes back blank for the next render.
 */
module line_buffer (
    input  logic                           clk96,
    input  logic                           reset96,
    input  logic                           swap_i,
    input  logic                           busy_i,
    input  scroll_pkg::buf_wr_t            buf_wr_i,
    input  logic                           pixel_cen_i,
    input  logic [8:0]                     h_i,
    output logic [scroll_pkg::PIXEL_W-1:0] pixel_o
);
    import scroll_pkg::*;

    logic [PIXEL_W-1:0] mem [2][512];
    logic               wr_sel;   // bank being rendered
    logic               rd_en;

    assign rd_en = pixel_cen_i && (h_i < 9'(SCREEN_W));

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            wr_sel  <= 1'b0;
            pixel_o <= '0;
        end else begin
            if (swap_i)
                wr_sel <= !wr_sel;
            if (rd_en)
                pixel_o <= mem[!wr_sel][h_i];
        end
    end

    always_ff @(posedge clk96) begin
        if (buf_wr_i.we)
            mem[wr_sel][buf_wr_i.addr] <= buf_wr_i.data;
        if (rd_en)
            mem[!wr_sel][h_i] <= '0;   // read and clear
    end

    // a swap while the render still writes would tear the line
    a_done_before_swap: assert property (@(posedge clk96) disable iff (reset96)
        swap_i |-> !busy_i);

endmodule

//--- scroll_layer.sv
/*
 * Top level of the single scroll layer. Detects the end of hblank to
 * swap the line banks and start the next line's fetch and render, and
 * tracks the render busy flag across fetch, queue and render.
 */
module scroll_layer (
    input  logic                          clk96,
    input  logic                          reset96,
    input  logic [3:0]                    paddr_i,
    input  logic                          psel_i,
    input  logic                          penable_i,
    input  logic                          pwrite_i,
    input  logic [31:0]                   pwdata_i,
    output logic [31:0]                   prdata_o,
    output logic                          pready_o,
    output logic                          pslverr_o,
    input  logic [8:0]                    vrender_i,
    input  logic [8:0]                    h_i,
    input  logic                          hblank_i,
    input  logic                          vblank_i,
    input  logic                          pixel_cen_i,
    input  scroll_pkg::map_word_t         map_data_i,
    input  scroll_pkg::gfx_rsp_t          gfx_rsp_i,
    output logic [scroll_pkg::MAP_AW-1:0] map_addr_o,
    output scroll_pkg::gfx_req_t          gfx_req_o,
    output logic [scroll_pkg::PIXEL_W-1:0] pixel_o
);
    import scroll_pkg::*;

    scroll_cfg_t  cfg, line_cfg;
    queue_entry_t fetch_entry, q_entry;
    buf_wr_t      buf_wr;
    logic         hb_q, swap, start, render_busy;
    logic         push, pop, q_valid, q_empty, fetch_done, rend_busy;
    logic [3:0]   push_prio, q_prio, tile_row;

    assign swap  = hb_q && !hblank_i;                 // hblank falling edge
    assign start = swap && !vblank_i && cfg.enable;

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            hb_q        <= 1'b0;
            line_cfg    <= '0;
            render_busy <= 1'b0;
        end else begin
            hb_q <= hblank_i;
            if (start) begin
                line_cfg    <= cfg;   // flip holds for the whole line
                render_busy <= 1'b1;
            end else if (fetch_done && q_empty && !rend_busy) begin
                render_busy <= 1'b0;
            end
        end
    end

    scroll_regs u_regs (
        .clk96, .reset96, .paddr_i, .psel_i, .penable_i, .pwrite_i, .pwdata_i,
        .prdata_o, .pready_o, .pslverr_o, .cfg_o(cfg)
    );

    tile_fetch u_fetch (
        .clk96, .reset96, .start_i(start), .vrender_i, .cfg_i(cfg), .map_data_i,
        .map_addr_o, .push_o(push), .push_prio_o(push_prio), .entry_o(fetch_entry),
        .tile_row_o(tile_row), .done_o(fetch_done)
    );

    prio_queue u_queue (
        .clk96, .reset96, .clear_i(start), .push_i(push), .push_prio_i(push_prio),
        .entry_i(fetch_entry), .pop_i(pop), .fetch_done_i(fetch_done),
        .entry_o(q_entry), .prio_o(q_prio), .valid_o(q_valid), .empty_o(q_empty)
    );

    tile_render u_render (
        .clk96, .reset96, .tile_row_i(tile_row), .entry_i(q_entry), .prio_i(q_prio),
        .valid_i(q_valid), .empty_i(q_empty), .cfg_i(line_cfg), .gfx_rsp_i,
        .pop_o(pop), .gfx_req_o, .buf_wr_o(buf_wr), .busy_o(rend_busy)
    );

    line_buffer u_linebuf (
        .clk96, .reset96, .swap_i(swap), .busy_i(render_busy), .buf_wr_i(buf_wr),
        .pixel_cen_i, .h_i, .pixel_o
    );

endmodule

//--- tb_scroll_layer.sv
/*
 * Testbench for the single tile-map scroll layer.
 * Generates line timing, models the tile-map RAM and the graphics ROM,
 * builds the expected line from the layer rules and compares every
 * displayed pixel. Directed tests run one video line each.
 */
module tb_scroll_layer;
    import scroll_pkg::*;

    logic        clk96, reset96;
    logic [3:0]  paddr_i;
    logic        psel_i, penable_i, pwrite_i;
    logic [31:0] pwdata_i, prdata_o;
    logic        pready_o, pslverr_o;
    logic [8:0]  vrender_i, h_i;
    logic        hblank_i, vblank_i, pixel_cen_i;
    map_word_t   map_data_i;
    gfx_rsp_t    gfx_rsp_i;
    gfx_req_t    gfx_req_o;
    logic [MAP_AW-1:0]  map_addr_o;
    logic [PIXEL_W-1:0] pixel_o;

    logic [15:0]        map_mem [8192];
    logic [15:0]        map_s0, map_s1;       // RAM read pipeline
    logic [PIXEL_W-1:0] ref_next [SCREEN_W];  // line now being rendered
    logic [PIXEL_W-1:0] ref_prev [SCREEN_W];  // line now on display
    int   h, phase, vline;
    bit   gen_on, rand_delay, gfx_pending;
    int   ok_wait;
    integer seed = 32'h9a06;

    scroll_layer scroll_layer_i (.*);

    initial begin
        clk96 = 1'b0;
        forever #20 clk96 = ~clk96;
    end

    initial begin
        #(12 * 1664 * 40);
        $display("watchdog expired before the tests finished");
        $display("RESULT: FAIL");
        $fatal(1);
    end

    // pixel timing with 4 clocks per pixel and 416 pixels per line
    always @(negedge clk96) begin
        if (gen_on) begin
            if (phase == 3) begin
                phase = 0;
                if (h == 415) begin
                    h     = 0;
                    vline = vline + 1;
                end else begin
                    h = h + 1;
                end
            end else begin
                phase = phase + 1;
            end
            h_i         = 9'(h);
            vrender_i   = 9'(vline);
            hblank_i    = (h >= SCREEN_W);
            pixel_cen_i = (phase == 1);   // off the swap cycle
        end
    end

    // tile-map RAM with the word valid 2 cycles after the address
    always @(negedge clk96) begin
        map_data_i = map_s1;
        map_s1     = map_s0;
        map_s0     = map_mem[map_addr_o];
    end

    function automatic logic [31:0] gfx_word(input logic [12:0] code, input logic [2:0] bank,
                                             input logic half, input logic [3:0] row);
        logic [31:0] k;
        logic [31:0] m;
        k = {11'd0, code, bank, half, row};
        m = k * 32'h9E3779B1;
        m = m ^ (m >> 13);
        m = m * 32'h85EBCA6B;
        m = m ^ (m >> 16);
        if (k[1:0] == 2'b01)
            m = m & 32'hF00F_FF00;   // some clear pixels
        return m;
    endfunction

    // graphics ROM with optional random ok delay
    always @(negedge clk96) begin
        if (gfx_rsp_i.ok) begin
            gfx_rsp_i = '0;
        end else if (gfx_req_o.cs) begin
            if (!gfx_pending) begin
                gfx_pending = 1'b1;
                ok_wait     = rand_delay ? ($random(seed) & 7) : 0;
            end
            if (ok_wait == 0) begin
                gfx_rsp_i.ok   = 1'b1;
                gfx_rsp_i.data = gfx_word(gfx_req_o.code, gfx_req_o.bank,
                                          gfx_req_o.half, gfx_req_o.row);
                gfx_pending    = 1'b0;
            end else begin
                ok_wait = ok_wait - 1;
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic apb_xfer(input bit wr, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(negedge clk96);
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = wr;
        paddr_i   = addr;
        pwdata_i  = wdata;
        @(negedge clk96);
        penable_i = 1'b1;
        @(posedge clk96);
        rdata = prdata_o;
        err   = pslverr_o;
        check_value("pready_o", pready_o, 1);
        @(negedge clk96);
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] wdata);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, addr, wdata, rd, err);
        check_value("pslverr_o", err, 0);
    endtask

    task automatic apb_expect(input logic [3:0] addr, input logic [31:0] exp,
                              input logic exp_err);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b0, addr, 0, rd, err);
        check_value("prdata_o", rd, exp);
        check_value("pslverr_o", err, exp_err);
    endtask

    task automatic test_registers();
        logic [31:0] rd;
        logic        err;
        apb_expect(REG_SCROLL_X, 0, 0);   // reset values
        apb_expect(REG_SCROLL_Y, 0, 0);
        apb_expect(REG_CTRL, 0, 0);
        apb_write(REG_SCROLL_X, 32'hFFFF_F2A5);
        apb_write(REG_SCROLL_Y, 32'h0000_0133);
        apb_write(REG_CTRL, 32'h0000_0002);
        apb_expect(REG_SCROLL_X, 32'h2A5, 0);   // 10 bits kept
        apb_expect(REG_SCROLL_Y, 32'h133, 0);
        apb_expect(REG_CTRL, 32'h2, 0);
        apb_xfer(1'b1, 4'hC, 32'hFFFF_FFFF, rd, err);
        check_value("pslverr_o", err, 1);
        apb_expect(4'hC, 0, 1);
        apb_expect(REG_SCROLL_X, 32'h2A5, 0);
        apb_expect(REG_SCROLL_Y, 32'h133, 0);
        apb_expect(REG_CTRL, 32'h2, 0);
        apb_write(REG_SCROLL_X, 0);
        apb_write(REG_SCROLL_Y, 0);
        apb_write(REG_CTRL, 0);
    endtask

    // mixed map or every tile present at level 9
    task automatic fill_map(input bit one_level);
        int t;
        for (int a = 0; a < 8192; a++) begin
            t = a >> 1;
            if (a % 2 == 0)
                map_mem[a] = one_level ? {4'h0, 4'd9, 1'b0, 7'(t * 5)}
                                       : {4'(t), 4'(t * 7 + (t >> 5)), 1'b0, 7'(t * 13)};
            else if (one_level)
                map_mem[a] = {3'(t), 13'(t + 1)};
            else
                map_mem[a] = (t % 6 == 2) ? 16'h0000 : {3'(t >> 1), 13'(t * 29 + 3)};
        end
    endtask

    task automatic build_reference(input int v, input int sx, input int sy,
                                   input bit flip, input bit en);
        int vpos, row, trow, col, a, pos;
        logic [15:0] attr, num;
        logic [31:0] d;
        logic [3:0]  pix;
        for (int c = 0; c < SCREEN_W; c++)
            ref_next[c] = '0;
        if (en) begin
            vpos = v + sy;
            row  = (vpos / 16) % 32;
            trow = vpos % 16;
            for (int lvl = 0; lvl < NUM_PRIO; lvl++) begin   // higher level paints last
                for (int i = 0; i < TILES_ACROSS; i++) begin
                    col  = ((sx / 16) + i) % 32;
                    a    = 2 * (row * 32 + col);
                    attr = map_mem[a];
                    num  = map_mem[a + 1];
                    if (num != 0 && int'(attr[11:8]) == lvl) begin
                        for (int half = 0; half < 2; half++) begin
                            d = gfx_word(num[12:0], num[15:13], half[0], 4'(trow));
                            for (int n = 0; n < 8; n++) begin
                                pix = d[4*n +: 4];
                                pos = 16 * i - (sx % 16) + 8 * half + n;
                                if (pix != 0 && pos >= 0 && pos < SCREEN_W)
                                    ref_next[flip ? 319 - pos : pos] =
                                        15'(lvl * 2048 + int'(attr[6:0]) * 16 + int'(pix));
                            end
                        end
                    end
                end
            end
        end
    endtask

    task automatic wait_line_start();
        do @(posedge clk96); while (!(h == 0 && phase == 0));
    endtask

    task automatic capture_line(input bit chk, input bit cs_idle);
        while (h < SCREEN_W) begin
            @(posedge clk96);
            if (cs_idle)
                check_value("gfx_req_o.cs", gfx_req_o.cs, 0);
            if (chk && h < SCREEN_W && phase == 3) begin
                if (ref_prev[h] != 0)
                    check_value("pixel_o prio", pixel_o[14:11], ref_prev[h][14:11]);
                check_value("pixel_o", pixel_o, ref_prev[h]);
            end
        end
    endtask

    // new config renders this line while the previous render is displayed
    task automatic run_line(input int sx, input int sy, input bit flip, input bit en,
                            input bit rnd, input bit chk, input bit cs_idle);
        apb_write(REG_SCROLL_X, sx);
        apb_write(REG_SCROLL_Y, sy);
        apb_write(REG_CTRL, {30'd0, flip, en});
        rand_delay = rnd;
        wait_line_start();
        ref_prev = ref_next;
        build_reference(vline, sx, sy, flip, en);
        capture_line(chk, cs_idle);
    endtask

    initial begin
        reset96     = 1'b1;
        paddr_i     = '0;
        psel_i      = 1'b0;
        penable_i   = 1'b0;
        pwrite_i    = 1'b0;
        pwdata_i    = '0;
        vrender_i   = '0;
        h_i         = 9'd400;
        hblank_i    = 1'b1;
        vblank_i    = 1'b0;
        pixel_cen_i = 1'b0;
        map_data_i  = '0;
        gfx_rsp_i   = '0;
        map_s0      = '0;
        map_s1      = '0;
        h           = 400;
        phase       = 0;
        vline       = 0;
        gen_on      = 1'b0;
        rand_delay  = 1'b0;
        gfx_pending = 1'b0;
        ok_wait     = 0;
        for (int c = 0; c < SCREEN_W; c++)
            ref_next[c] = '0;
        repeat (8) @(posedge clk96);
        @(negedge clk96);
        reset96 = 1'b0;
        gen_on  = 1'b1;
        test_registers();
        wait_line_start();   // this display line clears the next write bank
        fill_map(0);
        run_line(0, 0, 0, 1, 0, 0, 0);
        run_line(37, 90, 0, 1, 0, 1, 0);     // shows the unscrolled line
        run_line(300, 250, 0, 1, 0, 1, 0);   // shows the scrolled line
        fill_map(1);
        run_line(0, 0, 0, 1, 0, 1, 0);       // one full level
        fill_map(0);
        run_line(0, 0, 1, 1, 0, 1, 0);       // flip
        run_line(0, 0, 1, 1, 1, 1, 0);       // flip with random ok delays
        run_line(0, 0, 0, 0, 0, 1, 1);       // disabled
        run_line(0, 0, 0, 0, 0, 1, 1);       // blank line shown
        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- scroll_layer.f
scroll_pkg.sv
scroll_regs.sv
tile_fetch.sv
prio_queue.sv
tile_render.sv
line_buffer.sv
scroll_layer.sv
tb_scroll_layer.sv

//--- run_sim.sh
#!/bin/sh
# build and run the scroll layer testbench with Verilator
verilator --binary --timing -Wno-fatal --top-module tb_scroll_layer \
    -f scroll_layer.f -o tb_sim || exit 1
out=$(./obj_dir/tb_sim)
echo "$out"
echo "$out" | grep -q "RESULT: PASS" && exit 0 || exit 1
